/* src/busArb_config.svh */
`ifndef BUS_ARB_CONFIG_SVH
`define BUS_ARB_CONFIG_SVH

// Shared bus widths
`define BUS_ADDR_WIDTH 32
`define BUS_DATA_WIDTH 32

// On-chip memory depth in words
`define MEM_WORDS 256

// Extra data-phase cycles the memory adds to every transfer
// Zero gives a single-cycle data phase
`define MEM_WAIT_STATES 1

`endif

/* src/busArbPkg.sv */
`include "busArb_config.svh"

package busArbPkg;

    // Byte address on the shared bus
    typedef logic [`BUS_ADDR_WIDTH-1:0] busAddrT;

    // One data word, read or write
    typedef logic [`BUS_DATA_WIDTH-1:0] busDataT;

    // Transfer size, AHB coding
    typedef logic [2:0] xferSizeT;

    localparam xferSizeT SIZE_BYTE = 3'd0;
    localparam xferSizeT SIZE_HALF = 3'd1;
    localparam xferSizeT SIZE_WORD = 3'd2;

    // Owner of an address or data phase
    // T = walker, M = data cache, F = instruction cache
    typedef enum logic [1:0] {
        SEL_T,
        SEL_M,
        SEL_F,
        SEL_NONE
    } masterSelT;

    // Arbitration sequences for requests that arrive together
    // SINGLE grants by priority, the rest finish a started sequence
    typedef enum logic [2:0] {
        SINGLE,
        TMF2,
        TMF3,
        MF,
        TM,
        TF
    } arbStateT;

    // Address-phase bundle, per master and on the bus
    typedef struct packed {
        busAddrT  addr;
        xferSizeT size;
        logic     write;
    } addrPhaseT;

endpackage

/* src/arbiterController.sv */
module arbiterController (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 requestT,
    input  logic                 requestM,
    input  logic                 requestF,
    input  logic                 hready,
    output busArbPkg::masterSelT addrSel,
    output busArbPkg::masterSelT dataSel,
    output logic                 transferActive,
    output logic                 readyT,
    output logic                 readyM,
    output logic                 readyF
);
    import busArbPkg::*;

    arbStateT state;
    arbStateT nextState;
    logic     eligT;
    logic     eligM;
    logic     eligF;

    // Master still in its data phase sits out the next address phase
    // A request held through ready is taken one cycle later as a new one
    assign eligT = requestT && (dataSel != SEL_T);
    assign eligM = requestM && (dataSel != SEL_M);
    assign eligF = requestF && (dataSel != SEL_F);

    // Sequence choice in SINGLE
    // T beats M beats F, leftovers queue up in the sequence states
    always_comb begin
        nextState = SINGLE;
        case (state)
            SINGLE: begin
                if (eligT && eligM && eligF) begin
                    nextState = TMF2;
                end else if (eligT && eligM) begin
                    nextState = TM;
                end else if (eligT && eligF) begin
                    nextState = TF;
                end else if (eligM && eligF) begin
                    nextState = MF;
                end
            end
            TMF2:    nextState = TMF3;
            default: nextState = SINGLE;
        endcase
    end

    // Address-phase owner
    always_comb begin
        addrSel = SEL_NONE;
        case (state)
            SINGLE: begin
                if (eligT) begin
                    addrSel = SEL_T;
                end else if (eligM) begin
                    addrSel = SEL_M;
                end else if (eligF) begin
                    addrSel = SEL_F;
                end
            end
            // M is second in both of these
            TMF2, TM: begin
                if (eligM) begin
                    addrSel = SEL_M;
                end
            end
            // F always closes a sequence
            TMF3, MF, TF: begin
                if (eligF) begin
                    addrSel = SEL_F;
                end
            end
            default: addrSel = SEL_NONE;
        endcase
    end

    assign transferActive = (addrSel != SEL_NONE);

    // Accepted address phase becomes the data phase
    // Everything holds while the memory stalls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= SINGLE;
            dataSel <= SEL_NONE;
        end else if (hready) begin
            state   <= nextState;
            dataSel <= addrSel;
        end
    end

    // Ready goes only to the data-phase owner
    assign readyT = hready && (dataSel == SEL_T);
    assign readyM = hready && (dataSel == SEL_M);
    assign readyF = hready && (dataSel == SEL_F);

    // Never two transfers ending together
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({readyT, readyM, readyF}))
        else $error("arbiterController: more than one ready high");

    // Stall freezes the sequence and the data-phase owner
    assert property (@(posedge clk) disable iff (reset)
        !hready |=> $stable(state) && $stable(dataSel))
        else $error("arbiterController: state moved during a stall");

endmodule

/* src/masterPortMux.sv */
module masterPortMux (
    input  busArbPkg::addrPhaseT addrT,
    input  busArbPkg::addrPhaseT addrM,
    input  busArbPkg::addrPhaseT addrF,
    input  busArbPkg::busDataT   wdataM,
    input  busArbPkg::masterSelT addrSel,
    input  busArbPkg::masterSelT dataSel,
    output busArbPkg::addrPhaseT busAddrPhase,
    output busArbPkg::busDataT   busWdata
);
    import busArbPkg::*;

    // Idle bus: word read of address 0
    localparam addrPhaseT idlePhase = '{
        addr:  '0,
        size:  SIZE_WORD,
        write: 1'b0
    };

    // Address phase follows the current grant
    always_comb begin
        case (addrSel)
            SEL_T:   busAddrPhase = addrT;
            SEL_M:   busAddrPhase = addrM;
            SEL_F:   busAddrPhase = addrF;
            default: busAddrPhase = idlePhase;
        endcase
    end

    // Write data lags by one phase
    // dataSel is already the registered owner, so this lines up
    // with the memory's data phase
    always_comb begin
        if (dataSel == SEL_M) begin
            busWdata = wdataM;
        end else begin
            busWdata = '0;
        end
    end

    // Walker and fetch are read-only masters
    // A write here would land on the bus with no data behind it
    always_comb begin
        assert (!(busAddrPhase.write && (addrSel == SEL_T || addrSel == SEL_F)))
            else $error("masterPortMux: write from read-only master %s",
                        addrSel.name());
    end

endmodule

/* src/waitStateMemory.sv */
`include "busArb_config.svh"

module waitStateMemory #(
    parameter int waitStates = `MEM_WAIT_STATES
) (
    input  logic                 clk,
    input  logic                 reset,
    input  busArbPkg::addrPhaseT busAddrPhase,
    input  busArbPkg::busDataT   busWdata,
    input  logic                 transferActive,
    output logic                 hready,
    output busArbPkg::busDataT   rdata
);
    import busArbPkg::*;

    localparam int numLanes  = `BUS_DATA_WIDTH / 8;
    localparam int laneBits  = $clog2(numLanes);
    localparam int indexBits = $clog2(`MEM_WORDS);
    localparam int countBits = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

    typedef logic [indexBits-1:0] wordIndexT;
    typedef logic [countBits-1:0] waitCountT;
    typedef logic [numLanes-1:0]  laneMaskT;

    busDataT   mem [`MEM_WORDS];
    addrPhaseT dataPhase;
    logic      pending;
    waitCountT waitCount;
    wordIndexT wordIndex;
    laneMaskT  laneMask;
    logic      lastCycle;
    logic      accept;

    // Data phase ends when the wait counter runs out
    assign lastCycle = pending && (waitCount == '0);
    assign hready    = !pending || lastCycle;
    assign accept    = transferActive && hready;

    // A new phase may start in the last cycle of the old one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending   <= 1'b0;
            waitCount <= '0;
        end else if (accept) begin
            pending   <= 1'b1;
            waitCount <= waitCountT'(waitStates);
        end else if (lastCycle) begin
            pending <= 1'b0;
        end else if (pending) begin
            waitCount <= waitCount - 1'b1;
        end
    end

    // Address, size and direction of the transfer in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            dataPhase <= busAddrPhase;
        end
    end

    // Word address wraps at the memory depth
    assign wordIndex = dataPhase.addr[indexBits+1:2];

    // Lanes picked by size and low address bits
    always_comb begin
        case (dataPhase.size)
            SIZE_BYTE: laneMask = laneMaskT'(1) << dataPhase.addr[laneBits-1:0];
            SIZE_HALF: laneMask = laneMaskT'(3) << {dataPhase.addr[laneBits-1:1], 1'b0};
            default:   laneMask = '1;
        endcase
    end

    // Writes land on the last data-phase cycle only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < `MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (lastCycle && dataPhase.write) begin
            for (int b = 0; b < numLanes; b++) begin
                if (laneMask[b]) begin
                    mem[wordIndex][8*b +: 8] <= busWdata[8*b +: 8];
                end
            end
        end
    end

    // Whole word back on reads, masters pick their own lanes
    assign rdata = (lastCycle && !dataPhase.write) ? mem[wordIndex] : '0;

    // Halfword must not straddle a lane pair
    assert property (@(posedge clk) disable iff (reset)
        accept && (busAddrPhase.size == SIZE_HALF) |-> !busAddrPhase.addr[0])
        else $error("waitStateMemory: misaligned halfword at %h", busAddrPhase.addr);

endmodule

/* src/busSubsystem.sv */
module busSubsystem (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 requestT,
    input  logic                 requestM,
    input  logic                 requestF,
    input  busArbPkg::addrPhaseT addrT,
    input  busArbPkg::addrPhaseT addrM,
    input  busArbPkg::addrPhaseT addrF,
    input  busArbPkg::busDataT   wdataM,
    output logic                 readyT,
    output logic                 readyM,
    output logic                 readyF,
    output busArbPkg::busDataT   rdata
);
    import busArbPkg::*;

    masterSelT addrSel;
    masterSelT dataSel;
    logic      transferActive;
    logic      hready;
    addrPhaseT busAddrPhase;
    busDataT   busWdata;

    // Grant and ready generation
    arbiterController i_arbiterController (
        .clk            (clk),
        .reset          (reset),
        .requestT       (requestT),
        .requestM       (requestM),
        .requestF       (requestF),
        .hready         (hready),
        .addrSel        (addrSel),
        .dataSel        (dataSel),
        .transferActive (transferActive),
        .readyT         (readyT),
        .readyM         (readyM),
        .readyF         (readyF)
    );

    // Master address and write data onto the shared bus
    masterPortMux i_masterPortMux (
        .addrT        (addrT),
        .addrM        (addrM),
        .addrF        (addrF),
        .wdataM       (wdataM),
        .addrSel      (addrSel),
        .dataSel      (dataSel),
        .busAddrPhase (busAddrPhase),
        .busWdata     (busWdata)
    );

    // Single slave, read data fans out to all masters
    waitStateMemory i_waitStateMemory (
        .clk            (clk),
        .reset          (reset),
        .busAddrPhase   (busAddrPhase),
        .busWdata       (busWdata),
        .transferActive (transferActive),
        .hready         (hready),
        .rdata          (rdata)
    );

endmodule

/* testbench/busSubsystemTb.sv */
`include "busArb_config.svh"

module busSubsystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    import busArbPkg::*;

    localparam int clkPeriod  = 10;
    localparam int waitStates = `MEM_WAIT_STATES;
    // Request edge is age zero, ready is seen at edge waitStates+2
    localparam int readyAge   = waitStates + 1;
    localparam int numSeeds   = 8;
    localparam int numSized   = 16;
    localparam int numRounds  = 8;
    localparam int numTransfers   = numSeeds + 3 + 3 + 6 + 2 * numSized + 3 * numRounds;
    localparam int watchdogCycles = numTransfers * (waitStates + 2) * 3 + 200;

    logic      clk;
    logic      reset;
    logic      requestT;
    logic      requestM;
    logic      requestF;
    addrPhaseT addrT;
    addrPhaseT addrM;
    addrPhaseT addrF;
    busDataT   wdataM;
    logic      readyT;
    logic      readyM;
    logic      readyF;
    busDataT   rdata;

    // Reference copy of the memory
    busDataT shadow [`MEM_WORDS];
    busAddrT seedAddr [numSeeds];
    busDataT expT = '0;
    busDataT expM = '0;
    busDataT expF = '0;
    // Lone transfers from an idle bus, latency is fixed
    logic    lone = 1'b0;
    // All requests of a round rose together, priority order applies
    logic    ordered = 1'b0;
    int      reqAge;
    int      errorCount = 0;
    int      testCount = 0;
    int      testStartErrors = 0;

    busSubsystem i_busSubsystem (
        .clk      (clk),
        .reset    (reset),
        .requestT (requestT),
        .requestM (requestM),
        .requestF (requestF),
        .addrT    (addrT),
        .addrM    (addrM),
        .addrF    (addrF),
        .wdataM   (wdataM),
        .readyT   (readyT),
        .readyM   (readyM),
        .readyF   (readyF),
        .rdata    (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout after %0d cycles, some master never got its ready", watchdogCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Cycles since the first request of a transfer was seen
    always @(posedge clk) begin
        if (reset || !(requestT || requestM || requestF)) begin
            reqAge <= 0;
        end else begin
            reqAge <= reqAge + 1;
        end
    end

    task automatic logMismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("[FAIL] %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
        errorCount = errorCount + 1;
    endtask

    task automatic logFailure(input string what);
        $display("[FAIL] %0d ns %s", $time, what);
        errorCount = errorCount + 1;
    endtask

    // Checks sample mid-cycle, where DUT outputs have settled

    // Nothing completes under reset
    assert property (@(negedge clk) reset |-> !(readyT || readyM || readyF))
        else logFailure("ready high while reset is held");

    assert property (@(negedge clk) disable iff (reset) $onehot0({readyT, readyM, readyF}))
        else logFailure("more than one ready high in the same cycle");

    // Ready only to a master that asks
    assert property (@(negedge clk) disable iff (reset) readyT |-> requestT)
        else logFailure("readyT given while T was not requesting");
    assert property (@(negedge clk) disable iff (reset) readyM |-> requestM)
        else logFailure("readyM given while M was not requesting");
    assert property (@(negedge clk) disable iff (reset) readyF |-> requestF)
        else logFailure("readyF given while F was not requesting");

    // Read data against the reference copy
    assert property (@(negedge clk) disable iff (reset) readyT |-> rdata == expT)
        else logMismatch("rdata on readyT", expT, rdata);
    assert property (@(negedge clk) disable iff (reset)
        readyM && !addrM.write |-> rdata == expM)
        else logMismatch("rdata on readyM", expM, rdata);
    assert property (@(negedge clk) disable iff (reset) readyF |-> rdata == expF)
        else logMismatch("rdata on readyF", expF, rdata);

    // Higher priority master must be done first
    assert property (@(negedge clk) disable iff (reset) ordered && readyM |-> !requestT)
        else logFailure("M served while T was still waiting");
    assert property (@(negedge clk) disable iff (reset)
        ordered && readyF |-> !requestT && !requestM)
        else logFailure("F served while T or M was still waiting");

    assert property (@(negedge clk) disable iff (reset)
        lone && (readyT || readyM || readyF) |-> reqAge == readyAge)
        else logMismatch("ready latency", readyAge, reqAge);

    function automatic int shadowIndex(input busAddrT a);
        return int'((a >> 2) % `MEM_WORDS);
    endfunction

    // Byte lanes from size and low address bits
    function automatic busDataT mergeLanes(input busDataT old, input busDataT wdata,
                                           input busAddrT a, input xferSizeT size);
        busDataT merged;
        int      first;
        int      count;
        int      b;
        merged = old;
        case (size)
            SIZE_BYTE: begin
                first = int'(a[1:0]);
                count = 1;
            end
            SIZE_HALF: begin
                first = int'({a[1], 1'b0});
                count = 2;
            end
            default: begin
                first = 0;
                count = 4;
            end
        endcase
        for (b = first; b < first + count; b++) begin
            merged[8*b +: 8] = wdata[8*b +: 8];
        end
        return merged;
    endfunction

    // High bits stay random, memory wraps them
    function automatic busAddrT randomWordAddr();
        busAddrT a;
        a = $urandom;
        a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic idleCycle();
        @(posedge clk);
    endtask

    // Walker, word reads only
    task automatic walkerRead(input busAddrT a);
        requestT <= 1'b1;
        addrT    <= '{addr: a, size: SIZE_WORD, write: 1'b0};
        expT     <= shadow[shadowIndex(a)];
        @(negedge clk);
        while (!readyT) begin
            @(negedge clk);
        end
        @(posedge clk);
        requestT <= 1'b0;
    endtask

    // Data cache, sized reads and writes
    task automatic cacheAccess(input busAddrT a, input xferSizeT size, input logic write,
                               input busDataT wdata);
        requestM <= 1'b1;
        addrM    <= '{addr: a, size: size, write: write};
        wdataM   <= wdata;
        expM     <= shadow[shadowIndex(a)];
        @(negedge clk);
        while (!readyM) begin
            @(negedge clk);
        end
        if (write) begin
            shadow[shadowIndex(a)] = mergeLanes(shadow[shadowIndex(a)], wdata, a, size);
        end
        @(posedge clk);
        requestM <= 1'b0;
    endtask

    // Instruction fetch, word reads only
    task automatic fetchRead(input busAddrT a);
        requestF <= 1'b1;
        addrF    <= '{addr: a, size: SIZE_WORD, write: 1'b0};
        expF     <= shadow[shadowIndex(a)];
        @(negedge clk);
        while (!readyF) begin
            @(negedge clk);
        end
        @(posedge clk);
        requestF <= 1'b0;
    endtask

    task automatic beginTest();
        testCount = testCount + 1;
        testStartErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        $display("test %0d %s done, %0d new failures", testCount, name,
                 errorCount - testStartErrors);
    endtask

    initial begin
        busAddrT  a;
        busAddrT  aT;
        busAddrT  aM;
        busAddrT  aF;
        xferSizeT size;
        logic [2:0] pick;
        int       i;
        int       k;
        int       delayT;
        int       delayM;
        int       delayF;

        void'($urandom(32'hc6a0_2172));
        reset    <= 1'b1;
        requestT <= 1'b0;
        requestM <= 1'b0;
        requestF <= 1'b0;
        addrT    <= '{addr: '0, size: SIZE_WORD, write: 1'b0};
        addrM    <= '{addr: '0, size: SIZE_WORD, write: 1'b0};
        addrF    <= '{addr: '0, size: SIZE_WORD, write: 1'b0};
        wdataM   <= '0;
        // Memory clears on reset
        for (i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        beginTest();
        repeat (10) @(posedge clk);
        endTest("reset and idle");

        // Seed words through M, then one read per master
        beginTest();
        lone = 1'b1;
        for (i = 0; i < numSeeds; i++) begin
            seedAddr[i] = randomWordAddr();
            idleCycle();
            cacheAccess(seedAddr[i], SIZE_WORD, 1'b1, $urandom);
        end
        idleCycle();
        walkerRead(seedAddr[0]);
        idleCycle();
        cacheAccess(seedAddr[1], SIZE_WORD, 1'b0, '0);
        idleCycle();
        fetchRead(seedAddr[2]);
        lone = 1'b0;
        endTest("lone requests");

        beginTest();
        ordered = 1'b1;
        idleCycle();
        fork
            walkerRead(seedAddr[3]);
            cacheAccess(seedAddr[4], SIZE_WORD, 1'b0, '0);
            fetchRead(seedAddr[5]);
        join
        ordered = 1'b0;
        endTest("full contention");

        // TM, TF and MF pairs
        beginTest();
        ordered = 1'b1;
        idleCycle();
        fork
            walkerRead(seedAddr[6]);
            cacheAccess(seedAddr[7], SIZE_WORD, 1'b0, '0);
        join
        idleCycle();
        fork
            walkerRead(seedAddr[1]);
            fetchRead(seedAddr[0]);
        join
        idleCycle();
        fork
            cacheAccess(seedAddr[2], SIZE_WORD, 1'b0, '0);
            fetchRead(seedAddr[3]);
        join
        ordered = 1'b0;
        endTest("pairwise contention");

        // Sized writes into seeded words, each read back whole
        beginTest();
        lone = 1'b1;
        for (i = 0; i < numSized; i++) begin
            k = $urandom_range(numSeeds - 1, 0);
            size = xferSizeT'($urandom_range(2, 0));
            a = seedAddr[k];
            a[1:0] = 2'($urandom_range(3, 0));
            if (size == SIZE_HALF) begin
                a[0] = 1'b0;
            end else if (size == SIZE_WORD) begin
                a[1:0] = 2'b00;
            end
            idleCycle();
            cacheAccess(a, size, 1'b1, $urandom);
            idleCycle();
            cacheAccess({a[31:2], 2'b00}, SIZE_WORD, 1'b0, '0);
        end
        lone = 1'b0;
        endTest("sized writes");

        // Staggered random subsets, exclusivity and data checks only
        beginTest();
        for (i = 0; i < numRounds; i++) begin
            pick   = 3'($urandom_range(7, 1));
            delayT = $urandom_range(3, 0);
            delayM = $urandom_range(3, 0);
            delayF = $urandom_range(3, 0);
            k  = $urandom_range(numSeeds - 1, 0);
            aT = seedAddr[k];
            k  = $urandom_range(numSeeds - 1, 0);
            aM = seedAddr[k];
            k  = $urandom_range(numSeeds - 1, 0);
            aF = seedAddr[k];
            idleCycle();
            fork
                if (pick[0]) begin
                    repeat (delayT) @(posedge clk);
                    walkerRead(aT);
                end
                if (pick[1]) begin
                    repeat (delayM) @(posedge clk);
                    cacheAccess(aM, SIZE_WORD, 1'b0, '0);
                end
                if (pick[2]) begin
                    repeat (delayF) @(posedge clk);
                    fetchRead(aF);
                end
            join
        end
        endTest("exclusivity");

        $display("%0d tests run, %0d failures", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+src
src/busArbPkg.sv
src/arbiterController.sv
src/masterPortMux.sv
src/waitStateMemory.sv
src/busSubsystem.sv
testbench/busSubsystemTb.sv

/* Makefile */
TOP := busSubsystemTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
